//--- Makefile
VERILATOR = verilator
TOP = tb_spi_subsystem
FILELIST = verilog.f
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/axil_port.sv
`include "spi_macros.svh"

module axil_port import bus_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input axil_req_t host_req,
	output axil_rsp_t host_rsp,
	output periph_req_t preq,
	input logic grant,
	input periph_rsp_t prsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT,
		ST_RESP
	} state_e;

	state_e state;

	// Captured transaction
	logic req_write;
	logic [`ADDR_N - 1 : 0] req_addr;
	logic [`DATA_N - 1 : 0] req_data;

	// Captured answer
	logic resp_err;
	logic [`DATA_N - 1 : 0] resp_data;

	logic wr_acc, rd_acc;

	// Write wins when both are offered in the same cycle
	assign wr_acc = (state == ST_IDLE) && host_req.awvalid && host_req.wvalid;
	assign rd_acc = (state == ST_IDLE) && host_req.arvalid && !wr_acc;

	// ====================
	// Host side
	// ====================

	always_comb begin
		host_rsp.awready = wr_acc;
		host_rsp.wready = wr_acc;
		host_rsp.arready = rd_acc;
		host_rsp.bvalid = (state == ST_RESP) && req_write;
		host_rsp.bresp = resp_err ? AXIL_SLVERR : AXIL_OKAY;
		host_rsp.rvalid = (state == ST_RESP) && !req_write;
		host_rsp.rresp = resp_err ? AXIL_SLVERR : AXIL_OKAY;
		host_rsp.rdata = resp_data;
	end

	// Peripheral side, held until granted
	always_comb begin
		preq.valid = (state == ST_REQ);
		preq.write = req_write;
		preq.addr = req_addr;
		preq.data = req_data;
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			state <= ST_IDLE;
			req_write <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (wr_acc) begin
					req_write <= 1'b1;
					state <= ST_REQ;
				end else if (rd_acc) begin
					req_write <= 1'b0;
					state <= ST_REQ;
				end
			end
			ST_REQ:
				if (grant)
					state <= ST_WAIT;
			ST_WAIT:
				if (grant && prsp.valid)
					state <= ST_RESP;
			default:
				if (req_write ? host_req.bready : host_req.rready)
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys) begin
		if (wr_acc) begin
			req_addr <= host_req.awaddr[`ADDR_N - 1 : 0];
			req_data <= host_req.wdata;
		end else if (rd_acc) begin
			req_addr <= host_req.araddr[`ADDR_N - 1 : 0];
			req_data <= '0;
		end
		if (state == ST_WAIT && grant && prsp.valid) begin
			resp_err <= prsp.err;
			resp_data <= prsp.err ? '0 : prsp.data;
		end
	end

endmodule

//--- src/bus_arbiter.sv
module bus_arbiter import bus_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input periph_req_t req_a,
	input periph_req_t req_b,
	output logic grant_a,
	output logic grant_b,
	output periph_req_t preq,
	input periph_rsp_t prsp
);

	// Owner of the bus while busy, 1 means port b
	logic busy;
	logic owner;
	// Port served last, 1 means port b
	logic last;

	logic any_req;
	logic pick_b;

	assign any_req = req_a.valid || req_b.valid;

	// On a tie the port not served last goes first
	assign pick_b = req_b.valid && (!req_a.valid || !last);

	// ====================
	// Grants
	// ====================

	always_comb begin
		if (busy) begin
			grant_a = !owner;
			grant_b = owner;
		end else begin
			grant_a = req_a.valid && !pick_b;
			grant_b = pick_b;
		end
	end

	// Only the granting cycle reaches the controller
	always_comb begin
		preq = pick_b ? req_b : req_a;
		preq.valid = !busy && any_req;
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			busy <= 1'b0;
			owner <= 1'b0;
			last <= 1'b1;
		end else if (!busy) begin
			if (any_req) begin
				busy <= 1'b1;
				owner <= pick_b;
				last <= pick_b;
			end
		end else if (prsp.valid) begin
			busy <= 1'b0;
		end
	end

endmodule

//--- src/bus_pkg.sv
`include "spi_macros.svh"

package bus_pkg;

	// AXI4-Lite response codes used here
	typedef enum logic [1:0] {
		AXIL_OKAY   = 2'b00,
		AXIL_SLVERR = 2'b10
	} axil_resp_e;

	// Host to port, all five channels
	typedef struct packed {
		logic [`AXIL_ADDR_N - 1 : 0] awaddr;
		logic awvalid;
		logic [`DATA_N - 1 : 0] wdata;
		logic [`DATA_N / 8 - 1 : 0] wstrb;
		logic wvalid;
		logic [`AXIL_ADDR_N - 1 : 0] araddr;
		logic arvalid;
		logic bready;
		logic rready;
	} axil_req_t;

	// Port to host
	typedef struct packed {
		logic awready;
		logic wready;
		logic arready;
		axil_resp_e bresp;
		logic bvalid;
		logic [`DATA_N - 1 : 0] rdata;
		axil_resp_e rresp;
		logic rvalid;
	} axil_rsp_t;

	// ====================
	// Internal peripheral bus
	// ====================

	typedef struct packed {
		logic valid;
		logic write;
		logic [`ADDR_N - 1 : 0] addr;
		logic [`DATA_N - 1 : 0] data;
	} periph_req_t;

	typedef struct packed {
		logic valid;
		logic err;
		logic [`DATA_N - 1 : 0] data;
	} periph_rsp_t;

endpackage

//--- src/spi_controller.sv
`include "spi_macros.svh"

module spi_controller import bus_pkg::*, spi_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input periph_req_t preq,
	output periph_rsp_t prsp,
	output shift_cmd_t cmd,
	input shift_sts_t sts,
	output logic interrupt
);

	spi_ctrl_u ctrl;
	spi_stat_t stat;
	logic [`DATA_N - 1 : 0] tx_buf;
	logic [`DATA_N - 1 : 0] rx_data;
	logic start_q;

	// ====================
	// Address decode
	// ====================

	logic mapped;
	logic wr_ctrl, wr_data, rd_data;
	logic [`DATA_N - 1 : 0] rd_word;

	always_comb begin
		mapped = 1'b1;
		case (preq.addr)
		`SPI_CTRL: rd_word = ctrl.raw & `SPI_CTRL_MASK;
		`SPI_STAT: rd_word = `DATA_N'(stat) & `SPI_STAT_MASK;
		`SPI_DATA: rd_word = rx_data;
		default: begin
			rd_word = '0;
			mapped = 1'b0;
		end
		endcase
	end

	assign wr_ctrl = preq.valid && preq.write && (preq.addr == `SPI_CTRL);
	assign wr_data = preq.valid && preq.write && (preq.addr == `SPI_DATA);
	assign rd_data = preq.valid && !preq.write && (preq.addr == `SPI_DATA);

	// One cycle answer, writes read back zero
	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			prsp <= '0;
		end else begin
			prsp.valid <= preq.valid;
			prsp.err <= preq.valid && !mapped;
			prsp.data <= preq.write ? '0 : rd_word;
		end
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			ctrl.raw <= '0;
		else if (wr_ctrl)
			ctrl.raw <= preq.data & `SPI_CTRL_MASK;
	end

	always_ff @(posedge sys) begin
		if (wr_data)
			tx_buf <= preq.data;
		if (sts.done)
			rx_data <= sts.rx;
	end

	// ====================
	// Flags and transfer start
	// ====================

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			stat <= '{busy: 1'b0, rxne: 1'b0, txe: 1'b1};
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			// A queued byte goes out as soon as the shifter is free
			if (ctrl.f.en && !stat.txe && !stat.busy) begin
				start_q <= 1'b1;
				stat.busy <= 1'b1;
			end
			if (sts.done)
				stat.busy <= 1'b0;
			if (!ctrl.f.en) begin
				stat.txe <= 1'b1;
				stat.rxne <= 1'b0;
			end else begin
				if (wr_data)
					stat.txe <= 1'b0;
				else if (sts.loaded)
					stat.txe <= 1'b1;
				if (sts.done)
					stat.rxne <= 1'b1;
				else if (rd_data)
					stat.rxne <= 1'b0;
			end
		end
	end

	always_comb begin
		cmd.start = start_q;
		cmd.tx = tx_buf;
		cmd.pr_sel = ctrl.f.pr_sel;
		cmd.cpha = ctrl.f.cpha;
		cmd.cpol = ctrl.f.cpol;
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			interrupt <= 1'b0;
		else
			interrupt <= stat.rxne && ctrl.f.ie;
	end

endmodule

//--- src/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// ====================
// Widths
// ====================

// Data path of the peripheral and of the SPI frame
`define DATA_N 8

// Peripheral bus address, enough for the three registers
`define ADDR_N 4

// Host side address width
`define AXIL_ADDR_N 32

// Free running prescaler counter
`define PR_N 8

// ====================
// Register map
// ====================

`define SPI_CTRL 4'h0
`define SPI_STAT 4'h4
`define SPI_DATA 4'h8

// Readable bits, spare CTRL bit reads as zero
`define SPI_CTRL_MASK 8'hbf
`define SPI_STAT_MASK 8'h07

`endif

//--- src/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

	// CTRL fields, MSB first
	typedef struct packed {
		logic en;
		logic spare;
		logic ie;
		logic cpol;
		logic cpha;
		logic [2:0] pr_sel;
	} spi_ctrl_f_t;

	// Same CTRL word seen raw for bus access or as fields for the datapath
	typedef union packed {
		logic [`DATA_N - 1 : 0] raw;
		spi_ctrl_f_t f;
	} spi_ctrl_u;

	// STAT bits, txe in bit 0
	typedef struct packed {
		logic busy;
		logic rxne;
		logic txe;
	} spi_stat_t;

	// Controller to shift engine
	typedef struct packed {
		logic start;
		logic [`DATA_N - 1 : 0] tx;
		logic [2:0] pr_sel;
		logic cpha;
		logic cpol;
	} shift_cmd_t;

	// Shift engine back to controller
	typedef struct packed {
		logic loaded;
		logic done;
		logic [`DATA_N - 1 : 0] rx;
	} shift_sts_t;

endpackage

//--- src/spi_shifter.sv
`include "spi_macros.svh"

module spi_shifter import spi_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input shift_cmd_t cmd,
	output shift_sts_t sts,
	input logic miso,
	output logic sck,
	output logic mosi
);

	localparam int CNT_N = $clog2(`DATA_N + 1);

	// ====================
	// Prescaler
	// ====================

	logic [`PR_N - 1 : 0] pr_cnt;
	logic pr_bit_q;
	logic tick;

	always_ff @(posedge sys) begin
		if (!n_sh_reset || cmd.start) begin
			pr_cnt <= '0;
			pr_bit_q <= 1'b0;
		end else begin
			pr_cnt <= pr_cnt + 1'b1;
			pr_bit_q <= pr_cnt[cmd.pr_sel];
		end
	end

	// Falling edge of the selected bit, every 2^(pr_sel+1) cycles
	assign tick = pr_bit_q && !pr_cnt[cmd.pr_sel];

	// ====================
	// Shift engine
	// ====================

	logic active;
	logic half;
	logic [CNT_N - 1 : 0] bit_cnt;
	logic [`DATA_N - 1 : 0] sr;
	logic [`DATA_N - 1 : 0] rx_q;
	logic done_q;
	logic sample;
	logic last;

	// half is 0 before a leading edge and 1 before a trailing edge
	assign sample = (half == cmd.cpha);
	assign last = (bit_cnt == CNT_N'(`DATA_N)) && !half;

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			active <= 1'b0;
			half <= 1'b0;
			bit_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (cmd.start) begin
				active <= 1'b1;
				half <= 1'b0;
				bit_cnt <= '0;
				sck <= cmd.cpol;
				// With cpha clear the first bit must be out before the first edge
				if (!cmd.cpha)
					mosi <= cmd.tx[`DATA_N - 1];
			end else if (active) begin
				if (last) begin
					active <= 1'b0;
					done_q <= 1'b1;
				end else if (tick) begin
					half <= !half;
					sck <= !sck;
					if (sample)
						bit_cnt <= bit_cnt + 1'b1;
					else
						mosi <= sr[`DATA_N - 1];
				end
			end else begin
				sck <= cmd.cpol;
			end
		end
	end

	always_ff @(posedge sys) begin
		if (cmd.start)
			sr <= cmd.tx;
		else if (active && !last && tick && sample)
			sr <= {sr[`DATA_N - 2 : 0], miso};
		if (active && last)
			rx_q <= sr;
	end

	always_comb begin
		sts.loaded = cmd.start;
		sts.done = done_q;
		sts.rx = rx_q;
	end

endmodule

//--- src/spi_subsystem.sv
module spi_subsystem import bus_pkg::*, spi_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input axil_req_t host_a_req,
	output axil_rsp_t host_a_rsp,
	input axil_req_t host_b_req,
	output axil_rsp_t host_b_rsp,
	// Chip select has no function in master mode
	input logic cs,
	input logic miso,
	output logic mosi,
	output logic sck,
	output logic interrupt
);

	periph_req_t preq_a, preq_b, preq;
	periph_rsp_t prsp;
	logic grant_a, grant_b;
	shift_cmd_t cmd;
	shift_sts_t sts;

	// ====================
	// Host ports
	// ====================

	axil_port port_a_inst (.sys(sys), .n_sh_reset(n_sh_reset), .host_req(host_a_req),
		.host_rsp(host_a_rsp), .preq(preq_a), .grant(grant_a), .prsp(prsp));

	axil_port port_b_inst (.sys(sys), .n_sh_reset(n_sh_reset), .host_req(host_b_req),
		.host_rsp(host_b_rsp), .preq(preq_b), .grant(grant_b), .prsp(prsp));

	bus_arbiter bus_arbiter_inst (.sys(sys), .n_sh_reset(n_sh_reset), .req_a(preq_a),
		.req_b(preq_b), .grant_a(grant_a), .grant_b(grant_b), .preq(preq), .prsp(prsp));

	// ====================
	// SPI core
	// ====================

	spi_controller spi_controller_inst (.sys(sys), .n_sh_reset(n_sh_reset), .preq(preq),
		.prsp(prsp), .cmd(cmd), .sts(sts), .interrupt(interrupt));

	spi_shifter spi_shifter_inst (.sys(sys), .n_sh_reset(n_sh_reset), .cmd(cmd), .sts(sts),
		.miso(miso), .sck(sck), .mosi(mosi));

endmodule

//--- tests/spi_properties.sv
`include "spi_macros.svh"

module spi_properties import bus_pkg::*, spi_pkg::*; (
	input logic sys,
	input logic n_sh_reset,
	input axil_req_t host_a_req,
	input axil_rsp_t host_a_rsp,
	input axil_req_t host_b_req,
	input axil_rsp_t host_b_rsp,
	input periph_req_t preq,
	input shift_cmd_t cmd,
	input shift_sts_t sts,
	input logic sck,
	input logic interrupt
);

	// Transfer in progress, from start until the done pulse
	logic in_xfer;
	// Shadow of the CTRL interrupt enable
	logic ie_q;
	spi_ctrl_u ctrl_wr;

	// Channel order aw, w, ar, b, r
	logic [4:0] valid_a, valid_b;
	logic [4:0] pend_a, pend_b;

	assign ctrl_wr = preq.data;

	assign valid_a = {host_a_req.awvalid, host_a_req.wvalid, host_a_req.arvalid,
		host_a_rsp.bvalid, host_a_rsp.rvalid};
	assign pend_a = valid_a & ~{host_a_rsp.awready, host_a_rsp.wready, host_a_rsp.arready,
		host_a_req.bready, host_a_req.rready};
	assign valid_b = {host_b_req.awvalid, host_b_req.wvalid, host_b_req.arvalid,
		host_b_rsp.bvalid, host_b_rsp.rvalid};
	assign pend_b = valid_b & ~{host_b_rsp.awready, host_b_rsp.wready, host_b_rsp.arready,
		host_b_req.bready, host_b_req.rready};

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			in_xfer <= 1'b0;
			ie_q <= 1'b0;
		end else begin
			if (cmd.start)
				in_xfer <= 1'b1;
			else if (sts.done)
				in_xfer <= 1'b0;
			if (preq.valid && preq.write && preq.addr == `SPI_CTRL)
				ie_q <= ctrl_wr.f.ie;
		end
	end

	// ====================
	// Handshakes
	// ====================

	a_held_a: assert property (@(posedge sys) disable iff (!n_sh_reset)
		pend_a != '0 |=> (valid_a & $past(pend_a)) == $past(pend_a))
		else $error("port a dropped a valid before its ready");

	a_held_b: assert property (@(posedge sys) disable iff (!n_sh_reset)
		pend_b != '0 |=> (valid_b & $past(pend_b)) == $past(pend_b))
		else $error("port b dropped a valid before its ready");

	// ====================
	// SPI pins
	// ====================

	a_sck_idle: assert property (@(posedge sys) disable iff (!n_sh_reset)
		!in_xfer && $stable(cmd.cpol) |-> sck == cmd.cpol)
		else $error("sck left its idle level outside a transfer");

	a_irq_ie: assert property (@(posedge sys) disable iff (!n_sh_reset)
		$rose(interrupt) |-> $past(ie_q))
		else $error("interrupt rose with ie clear");

endmodule

bind spi_subsystem spi_properties spi_properties_inst (
	.sys(sys),
	.n_sh_reset(n_sh_reset),
	.host_a_req(host_a_req),
	.host_a_rsp(host_a_rsp),
	.host_b_req(host_b_req),
	.host_b_rsp(host_b_rsp),
	.preq(preq),
	.cmd(cmd),
	.sts(sts),
	.sck(sck),
	.interrupt(interrupt)
);

//--- tests/spi_vectors.txt
# name port op offset data expect resp
# port 0 or 1, op W write, R read, P poll STAT, I interrupt, X write with read on the other port
# offset, data, expect and resp in hex, resp 0 is OKAY and 2 is SLVERR
ctrl_wr   0 W 0 ff 00 0
ctrl_rd   0 R 0 00 bf 0
stat_en   0 R 4 00 01 0
m0_cfg    0 W 0 80 00 0
m0_tx     0 W 8 a5 00 0
m0_poll   0 P 4 00 03 0
m0_rx     0 R 8 00 a5 0
m1_cfg    1 W 0 89 00 0
m1_tx     1 W 8 3c 00 0
m1_poll   1 P 4 00 03 0
m1_rx     1 R 8 00 3c 0
m2_cfg    0 W 0 90 00 0
m2_tx     0 W 8 c3 00 0
m2_poll   0 P 4 00 03 0
m2_rx     0 R 8 00 c3 0
m3_cfg    1 W 0 b9 00 0
m3_tx     1 W 8 5a 00 0
irq_lo    0 I 0 00 00 0
m3_poll   1 P 4 00 03 0
irq_hi    0 I 0 00 01 0
m3_rx     1 R 8 00 5a 0
irq_clr   0 I 0 00 00 0
bad_wr    0 W c 12 00 2
bad_rd    1 R c 00 00 2
race_a    0 X 0 b9 b9 0
race_b    1 X 4 00 01 0

//--- tests/tb_spi_subsystem.sv
`include "spi_macros.svh"

module tb_spi_subsystem import bus_pkg::*, spi_pkg::*; ();

	logic sys = 1'b0;
	logic n_sh_reset;
	logic cs;
	logic miso;
	logic mosi;
	logic sck;
	logic interrupt;
	axil_req_t host_req [2];
	axil_rsp_t host_a_rsp;
	axil_rsp_t host_b_rsp;

	// Vector table with one entry per vector line
	string name_q[$];
	string op_q[$];
	int port_q[$];
	logic [`ADDR_N - 1 : 0] off_q[$];
	logic [`DATA_N - 1 : 0] data_q[$];
	logic [`DATA_N - 1 : 0] exp_q[$];
	axil_resp_e resp_q[$];

	int unsigned cycles = 0;
	int unsigned limit = 1000000;

	// SPI clock edges seen so far
	int unsigned sck_edges = 0;
	logic sck_q = 1'b0;

	always #20 sys = ~sys;

	// Loopback so every byte comes back as sent
	assign miso = mosi;

	spi_subsystem spi_subsystem_inst (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.host_a_req(host_req[0]),
		.host_a_rsp(host_a_rsp),
		.host_b_req(host_req[1]),
		.host_b_rsp(host_b_rsp),
		.cs(cs),
		.miso(miso),
		.mosi(mosi),
		.sck(sck),
		.interrupt(interrupt)
	);

	task automatic fail_now();
		$display("** FAIL **");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(posedge sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout, the vectors did not finish within %0d cycles", limit);
			fail_now();
		end
	end

	always @(negedge sys) begin
		if (sck !== sck_q)
			sck_edges <= sck_edges + 1;
		sck_q <= sck;
	end

	// ====================
	// Compare tasks
	// ====================

	task automatic check_data(input string name, input logic [`DATA_N - 1 : 0] exp,
		input logic [`DATA_N - 1 : 0] act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		if (act !== exp) begin
			$display("ERR %s expected resp %h actual resp %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected interrupt %b actual %b", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_edges(input string name, input int unsigned exp,
		input int unsigned act);
		if (act !== exp) begin
			$display("ERR %s expected %0d sck edges actual %0d", name, exp, act);
			fail_now();
		end
	endtask

	// ====================
	// Bus tasks
	// ====================

	function automatic axil_rsp_t port_rsp(input int p);
		return (p == 0) ? host_a_rsp : host_b_rsp;
	endfunction

	task automatic axil_write(input int p, input logic [`ADDR_N - 1 : 0] addr,
		input logic [`DATA_N - 1 : 0] data, output axil_resp_e resp);
		axil_rsp_t rsp;
		@(posedge sys);
		#2;
		host_req[p].awaddr = `AXIL_ADDR_N'(addr);
		host_req[p].awvalid = 1'b1;
		host_req[p].wdata = data;
		host_req[p].wstrb = '1;
		host_req[p].wvalid = 1'b1;
		host_req[p].bready = 1'b1;
		// Ready is sampled at the falling edge and the transfer lands on the next rising edge
		do begin
			@(negedge sys);
			rsp = port_rsp(p);
		end while (!(rsp.awready && rsp.wready));
		@(posedge sys);
		#2;
		host_req[p].awvalid = 1'b0;
		host_req[p].wvalid = 1'b0;
		do begin
			@(negedge sys);
			rsp = port_rsp(p);
		end while (!rsp.bvalid);
		resp = rsp.bresp;
		@(posedge sys);
		#2;
		host_req[p].bready = 1'b0;
	endtask

	task automatic axil_read(input int p, input logic [`ADDR_N - 1 : 0] addr,
		output logic [`DATA_N - 1 : 0] data, output axil_resp_e resp);
		axil_rsp_t rsp;
		@(posedge sys);
		#2;
		host_req[p].araddr = `AXIL_ADDR_N'(addr);
		host_req[p].arvalid = 1'b1;
		host_req[p].rready = 1'b1;
		do begin
			@(negedge sys);
			rsp = port_rsp(p);
		end while (!rsp.arready);
		@(posedge sys);
		#2;
		host_req[p].arvalid = 1'b0;
		do begin
			@(negedge sys);
			rsp = port_rsp(p);
		end while (!rsp.rvalid);
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge sys);
		#2;
		host_req[p].rready = 1'b0;
	endtask

	// Reads STAT until RXNE shows up
	task automatic poll_stat(input int p, output logic [`DATA_N - 1 : 0] data,
		output axil_resp_e resp);
		spi_stat_t stat;
		do begin
			axil_read(p, `SPI_STAT, data, resp);
			stat = data[2:0];
		end while (!stat.rxne);
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		string t_name;
		string t_op;
		int t_port;
		logic [31:0] t_off, t_data, t_exp, t_resp;
		fd = $fopen("tests/spi_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file tests/spi_vectors.txt");
			fail_now();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %d %s %h %h %h %h", t_name, t_port, t_op, t_off, t_data,
				t_exp, t_resp);
			// Comment and blank lines never give all seven fields
			if (n == 7) begin
				name_q.push_back(t_name);
				port_q.push_back(t_port);
				op_q.push_back(t_op);
				off_q.push_back(t_off[`ADDR_N - 1 : 0]);
				data_q.push_back(t_data[`DATA_N - 1 : 0]);
				exp_q.push_back(t_exp[`DATA_N - 1 : 0]);
				resp_q.push_back(axil_resp_e'(t_resp[1:0]));
			end
		end
		$fclose(fd);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		logic [`DATA_N - 1 : 0] rdata;
		axil_resp_e resp;
		axil_resp_e resp_b;
		int other;
		int unsigned edge_mark;
		host_req[0] = '0;
		host_req[1] = '0;
		cs = 1'b1;
		n_sh_reset = 1'b0;
		edge_mark = 0;
		load_vectors();
		// Longest transfer is 16 half periods of 256 cycles
		limit = name_q.size() * 16 * 256 + 2000;
		repeat (4) @(posedge sys);
		#2;
		n_sh_reset = 1'b1;
		for (int i = 0; i < name_q.size(); i++) begin
			other = 1 - port_q[i];
			if (op_q[i] == "W") begin
				// A DATA write starts a transfer, count its sck edges from here
				if (off_q[i] == `SPI_DATA)
					edge_mark = sck_edges;
				axil_write(port_q[i], off_q[i], data_q[i], resp);
				check_resp(name_q[i], resp_q[i], resp);
			end else if (op_q[i] == "R") begin
				axil_read(port_q[i], off_q[i], rdata, resp);
				check_data(name_q[i], exp_q[i], rdata);
				check_resp(name_q[i], resp_q[i], resp);
			end else if (op_q[i] == "P") begin
				poll_stat(port_q[i], rdata, resp);
				check_data(name_q[i], exp_q[i], rdata);
				check_resp(name_q[i], resp_q[i], resp);
				// One sck edge per half period
				check_edges(name_q[i], 2 * `DATA_N, sck_edges - edge_mark);
			end else if (op_q[i] == "I") begin
				@(negedge sys);
				check_irq(name_q[i], exp_q[i][0], interrupt);
			end else if (op_q[i] == "X") begin
				// Both ports start in the same cycle and either may win the grant
				fork
					axil_write(port_q[i], off_q[i], data_q[i], resp);
					axil_read(other, off_q[i], rdata, resp_b);
				join
				check_resp(name_q[i], resp_q[i], resp);
				check_data(name_q[i], exp_q[i], rdata);
				check_resp(name_q[i], resp_q[i], resp_b);
			end else begin
				$display("Unknown operation %s in vector %s", op_q[i], name_q[i]);
				fail_now();
			end
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+src
src/bus_pkg.sv
src/spi_pkg.sv
src/axil_port.sv
src/bus_arbiter.sv
src/spi_controller.sv
src/spi_shifter.sv
src/spi_subsystem.sv
tests/spi_properties.sv
tests/tb_spi_subsystem.sv
